// File: verif/mci_trace_vectors.txt
# T insn addr exc cause intr tval | W addr data | R addr expect | L lock | I cycles
# Q rec word0 word1 word2 word3 | N count of random beats | S test number | E end of test
S 1
R 50 00000000
R 51 00000000
R 52 00000000
E
S 2
T 00000013 80000000 0 00 0 00000000
T 00a00093 80000004 1 02 0 00000bad
T 30200073 80000008 1 1f 1 deadbeef
Q 0 00000013 80000000 00000000 00000000
Q 2 30200073 80000008 deadbeef 0000031f
R 51 00000003
R 50 00000002
E
S 3
N 8
R 50 00000003
R 51 00000003
E
S 4
I 2
L 1
T 11111111 22222222 0 05 1 33333333
R 50 00000000
R 51 00000000
R 52 00000000
R 53 00000000
R 7f 00000000
L 0
Q 3 11111111 22222222 33333333 00000205
R 51 00000004
E
S 5
N 10
E
S 6
W 52 00000015
R 52 00000015
W 53 12345678
R 52 00000015
R 7f 00000000
R 51 00000006
R 50 00000003
E

// File: filelist.f
+incdir+include
hdl/mci_trace_pkg.sv
hdl/mci_dmi_pkg.sv
hdl/mci_trace_capture.sv
hdl/mci_trace_ring.sv
hdl/mci_trace_dmi_regs.sv
hdl/mci_trace_top.sv
verif/mci_trace_assert.sv
verif/mci_trace_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the trace path testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mci_trace_tb -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmci_trace_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "No errors" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: verif/mci_trace_tb.sv
/* Testbench of the MCU trace path, driven by the command lines of a vectors file.
   Checks DMI read data against file values and against a reference model of the ring. */
`include "mci_trace_macros.svh"

module mci_trace_tb
    import mci_trace_pkg::*;
    import mci_dmi_pkg::*;
();

    logic            clk;
    logic            rst_n;
    logic            debug_locked;
    logic            trace_valid;
    mci_trace_port_t trace;
    mci_dmi_req_t    dmi_req;
    mci_dmi_word_t   dmi_rdata;

    // Reference model of the ring
    logic [31:0] model_mem [`MCI_TRACE_DEPTH][`MCI_TRACE_WORDS];
    int          model_wr_ptr;
    logic        model_wrapped;
    logic        model_valid;
    logic [4:0]  model_rd_ptr;

    int     checks;
    int     errors;
    int     cycles;
    int     cycle_limit;
    integer seed = 12658;

    mci_trace_top UUT (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .debug_locked_i (debug_locked),
        .trace_valid_i  (trace_valid),
        .trace_i        (trace),
        .dmi_req_i      (dmi_req),
        .dmi_rdata_o    (dmi_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout, the vectors did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_word(input string name, input mci_dmi_word_t got,
                              input mci_dmi_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_status(input mci_trace_status_t got, input mci_trace_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: dmi_rdata_o (status) is %08h, expected %08h",
                     $time, got, exp);
        end
    endtask

    //////////////////////////////
    // Bus drivers
    //////////////////////////////

    task automatic send_beat(input mci_trace_port_t beat);
        @(posedge clk);
        trace_valid <= 1'b1;
        trace       <= beat;
        @(posedge clk);
        trace_valid <= 1'b0;
        model_mem[model_wr_ptr][0] = beat.insn;
        model_mem[model_wr_ptr][1] = beat.addr;
        model_mem[model_wr_ptr][2] = beat.tval;
        // Cause in bits 4..0, exception in 8, interrupt in 9
        model_mem[model_wr_ptr][3] = {22'd0, beat.interrupt, beat.exception, 3'd0, beat.ecause};
        model_wrapped = model_wrapped | (model_wr_ptr == `MCI_TRACE_DEPTH - 1);
        model_valid   = 1'b1;
        model_wr_ptr  = (model_wr_ptr + 1) % `MCI_TRACE_DEPTH;
    endtask

    task automatic dmi_write(input logic [`MCI_DMI_ADDR_W-1:0] addr, input mci_dmi_word_t data);
        @(posedge clk);
        dmi_req <= {1'b1, 1'b1, addr, data};
        @(posedge clk);
        dmi_req.en <= 1'b0;
        if (addr == `MCI_DMI_RD_PTR_ADDR) begin
            model_rd_ptr = data[4:0];
        end
    endtask

    task automatic read_check(input logic [`MCI_DMI_ADDR_W-1:0] addr, input mci_dmi_word_t exp);
        mci_dmi_word_t got;
        @(posedge clk);
        dmi_req <= {1'b1, 1'b0, addr, 32'd0};
        @(posedge clk);
        dmi_req.en <= 1'b0;
        // Read data is loaded on the strobe edge
        @(negedge clk);
        got = dmi_rdata;
        if (addr == `MCI_DMI_STATUS_ADDR) begin
            check_status(mci_trace_status_t'(got), mci_trace_status_t'(exp));
        end else begin
            check_word($sformatf("dmi_rdata_o (addr %02h)", addr), got, exp);
        end
    endtask

    task automatic read_entry(input int rec, input int word, input mci_dmi_word_t exp);
        dmi_write(`MCI_DMI_RD_PTR_ADDR, mci_dmi_word_t'(rec * `MCI_TRACE_WORDS + word));
        read_check(`MCI_DMI_DATA_ADDR, exp);
    endtask

    task automatic random_beats(input int count);
        mci_trace_port_t beat;
        logic [127:0]    rnd;
        int              idx;
        for (int i = 0; i < count; i++) begin
            rnd  = {$random(seed), $random(seed), $random(seed), $random(seed)};
            beat = rnd[102:0];
            send_beat(beat);
        end
        // Newest record first, back to the oldest one still held
        for (int i = 0; i < count && i < `MCI_TRACE_DEPTH; i++) begin
            idx = (model_wr_ptr + `MCI_TRACE_DEPTH - 1 - i) % `MCI_TRACE_DEPTH;
            for (int w = 0; w < `MCI_TRACE_WORDS; w++) begin
                read_entry(idx, w, model_mem[idx][w]);
            end
        end
        read_check(`MCI_DMI_WR_PTR_ADDR, mci_dmi_word_t'(model_wr_ptr));
        read_check(`MCI_DMI_RD_PTR_ADDR, mci_dmi_word_t'(model_rd_ptr));
        read_check(`MCI_DMI_STATUS_ADDR, {30'd0, model_valid, model_wrapped});
    endtask

    //////////////////////////////
    // Vector sequencer
    //////////////////////////////

    initial begin
        int              fd;
        int              code;
        int              lines;
        int              asrt_fails;
        int              test_num;
        int              test_checks;
        int              test_errors;
        logic [7:0]      cmd;
        logic [31:0]     f [6];
        string           text;
        mci_trace_port_t beat;

        rst_n         = 1'b0;
        debug_locked  = 1'b0;
        trace_valid   = 1'b0;
        trace         = '0;
        dmi_req       = '0;
        model_wr_ptr  = 0;
        model_wrapped = 1'b0;
        model_valid   = 1'b0;
        model_rd_ptr  = '0;

        // Run limit scales with the number of vector lines
        fd = $fopen("verif/mci_trace_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/mci_trace_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(text, fd);
                if (code > 0) begin
                    lines++;
                end
            end
            $fclose(fd);
            fd = $fopen("verif/mci_trace_vectors.txt", "r");
        end
        cycle_limit = 8 * lines + 200;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        while (fd != 0 && $fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": code = $fgets(text, fd);
                "S": begin
                    code        = $fscanf(fd, "%d", test_num);
                    test_checks = checks;
                    test_errors = errors;
                end
                "E": $display("Test %0d finished with %0d checks and %0d errors", test_num,
                              checks - test_checks, errors - test_errors);
                "T": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                    beat.insn      = f[0];
                    beat.addr      = f[1];
                    beat.exception = f[2][0];
                    beat.ecause    = f[3][4:0];
                    beat.interrupt = f[4][0];
                    beat.tval      = f[5];
                    send_beat(beat);
                end
                "W": begin
                    code = $fscanf(fd, "%h %h", f[0], f[1]);
                    dmi_write(f[0][6:0], f[1]);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", f[0], f[1]);
                    read_check(f[0][6:0], f[1]);
                end
                "Q": begin
                    code = $fscanf(fd, "%d %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                    for (int w = 0; w < `MCI_TRACE_WORDS; w++) begin
                        read_entry(f[0], w, f[w + 1]);
                    end
                end
                "L": begin
                    code = $fscanf(fd, "%h", f[0]);
                    @(posedge clk);
                    debug_locked <= f[0][0];
                end
                "I": begin
                    code = $fscanf(fd, "%d", f[0]);
                    repeat (f[0]) @(posedge clk);
                end
                "N": begin
                    code = $fscanf(fd, "%d", f[0]);
                    random_beats(f[0]);
                end
                default: begin
                    $display("Unknown command '%c' in the vectors file", cmd);
                    errors++;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        repeat (2) @(posedge clk);
        asrt_fails = UUT.u_trace_assert.fail_cnt;
        $display("Checks passed: %0d, checks failed: %0d, assertion failures: %0d",
                 checks - errors, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verif/mci_trace_assert.sv
/* Concurrent checks on the trace top level, attached by bind.
   Covers locked read data, capture latency and read data hold. */
module mci_trace_assert
    import mci_dmi_pkg::*;
(
    input logic          clk,
    input logic          rst_n_i,
    input logic          debug_locked_i,
    input logic          trace_valid_i,
    input logic          rec_wr_i,
    input mci_dmi_req_t  dmi_req_i,
    input mci_dmi_word_t dmi_rdata_i
);

    logic rd_stb;
    int   fail_cnt = 0;

    assign rd_stb = dmi_req_i.en && !dmi_req_i.wr_en;

    // Locked debug returns zero
    locked_read_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_stb && debug_locked_i |=> dmi_rdata_i == '0)
    else begin
        $error("Read data not zero after a read while debug is locked");
        fail_cnt++;
    end

    capture_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        rec_wr_i == $past(trace_valid_i))
    else begin
        $error("Record write strobe does not follow the trace strobe by one cycle");
        fail_cnt++;
    end

    // Held until the next read
    rdata_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        !rd_stb |=> $stable(dmi_rdata_i))
    else begin
        $error("Read data changed without a read strobe");
        fail_cnt++;
    end

endmodule

bind mci_trace_top mci_trace_assert u_trace_assert (
    .clk,
    .rst_n_i,
    .debug_locked_i,
    .trace_valid_i,
    .rec_wr_i    (rec_wr),
    .dmi_req_i,
    .dmi_rdata_i (dmi_rdata_o)
);

// File: hdl/mci_trace_top.sv
/* Top level of the MCU trace path: capture, ring buffer and DMI registers.
   Trace strobe in, debugger reads through the DMI register port. */
`include "mci_trace_macros.svh"

module mci_trace_top
    import mci_trace_pkg::*;
    import mci_dmi_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            debug_locked_i,
    input  logic            trace_valid_i,
    input  mci_trace_port_t trace_i,
    input  mci_dmi_req_t    dmi_req_i,
    output mci_dmi_word_t   dmi_rdata_o
);

    // Capture to ring
    logic                           rec_wr;
    mci_trace_rec_t                 rec;

    // Ring and DMI block
    logic [`MCI_TRACE_RD_PTR_W-1:0] rd_ptr;
    mci_dmi_word_t                  rd_word;
    logic [`MCI_TRACE_PTR_W-1:0]    wr_ptr;
    mci_trace_status_t              status;

    mci_trace_capture i_mci_trace_capture (
        .clk,
        .rst_n_i,
        .trace_valid_i,
        .trace_i,
        .rec_wr_o (rec_wr),
        .rec_o    (rec)
    );

    mci_trace_ring i_mci_trace_ring (
        .clk,
        .rst_n_i,
        .rec_wr_i  (rec_wr),
        .rec_i     (rec),
        .rd_ptr_i  (rd_ptr),
        .rd_word_o (rd_word),
        .wr_ptr_o  (wr_ptr),
        .status_o  (status)
    );

    mci_trace_dmi_regs i_mci_trace_dmi_regs (
        .clk,
        .rst_n_i,
        .debug_locked_i,
        .dmi_req_i,
        .rd_word_i (rd_word),
        .wr_ptr_i  (wr_ptr),
        .status_i  (status),
        .rd_ptr_o  (rd_ptr),
        .rdata_o   (dmi_rdata_o)
    );

endmodule

// File: hdl/mci_trace_dmi_regs.sv
/* DMI register block of the trace buffer: status, pointers and data word.
   Owns the read pointer and returns zero on every read while debug is locked. */
`include "mci_trace_macros.svh"

module mci_trace_dmi_regs
    import mci_dmi_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           debug_locked_i,
    input  mci_dmi_req_t                   dmi_req_i,
    input  mci_dmi_word_t                  rd_word_i,
    input  logic [`MCI_TRACE_PTR_W-1:0]    wr_ptr_i,
    input  mci_trace_status_t              status_i,
    output logic [`MCI_TRACE_RD_PTR_W-1:0] rd_ptr_o,
    output mci_dmi_word_t                  rdata_o
);

    logic                           rd_stb;
    logic                           rd_ptr_wr;
    logic [`MCI_TRACE_RD_PTR_W-1:0] rd_ptr_q;
    mci_dmi_word_t                  rdata_d;
    mci_dmi_word_t                  rdata_q;

    //////////////////////////////
    // Request decode
    //////////////////////////////

    assign rd_stb    = dmi_req_i.en && !dmi_req_i.wr_en;
    // Only RD_PTR is writable
    assign rd_ptr_wr = dmi_req_i.en && dmi_req_i.wr_en &&
                       (dmi_req_i.addr == `MCI_DMI_RD_PTR_ADDR);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
        end else if (rd_ptr_wr) begin
            rd_ptr_q <= dmi_req_i.wdata[`MCI_TRACE_RD_PTR_W-1:0];
        end
    end

    //////////////////////////////
    // Read data
    //////////////////////////////

    always_comb begin
        case (dmi_req_i.addr)
            `MCI_DMI_STATUS_ADDR: rdata_d = mci_dmi_word_t'(status_i);
            `MCI_DMI_WR_PTR_ADDR: rdata_d = mci_dmi_word_t'(wr_ptr_i);
            `MCI_DMI_RD_PTR_ADDR: rdata_d = mci_dmi_word_t'(rd_ptr_q);
            `MCI_DMI_DATA_ADDR:   rdata_d = rd_word_i;
            default:              rdata_d = '0;
        endcase
        // Locked debug hides the whole buffer
        if (debug_locked_i) begin
            rdata_d = '0;
        end
    end

    // Held until the next read
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (rd_stb) begin
            rdata_q <= rdata_d;
        end
    end

    assign rd_ptr_o = rd_ptr_q;
    assign rdata_o  = rdata_q;

endmodule

// File: hdl/mci_trace_ring.sv
/* Ring buffer of trace records, oldest entry overwritten when full.
   Write side from the capture stage, word read side for the DMI block. */
`include "mci_trace_macros.svh"

module mci_trace_ring
    import mci_trace_pkg::*;
    import mci_dmi_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           rec_wr_i,
    input  mci_trace_rec_t                 rec_i,
    input  logic [`MCI_TRACE_RD_PTR_W-1:0] rd_ptr_i,
    output mci_dmi_word_t                  rd_word_o,
    output logic [`MCI_TRACE_PTR_W-1:0]    wr_ptr_o,
    output mci_trace_status_t              status_o
);

    mci_trace_rec_t                                mem [`MCI_TRACE_DEPTH];
    logic [`MCI_TRACE_PTR_W-1:0]                   wr_ptr_q;
    logic                                          wrapped_q;
    logic                                          valid_q;
    logic [`MCI_TRACE_WORDS-1:0][`MCI_DMI_DATA_W-1:0] rd_rec_words;

    //////////////////////////////
    // Write side
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q  <= '0;
            wrapped_q <= 1'b0;
            valid_q   <= 1'b0;
        end else if (rec_wr_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
            valid_q  <= 1'b1;
            // Sticky until reset
            if (wr_ptr_q == `MCI_TRACE_PTR_W'(`MCI_TRACE_DEPTH - 1)) begin
                wrapped_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rec_wr_i) begin
            mem[wr_ptr_q] <= rec_i;
        end
    end

    //////////////////////////////
    // Read side
    //////////////////////////////

    // Upper pointer bits pick the record, low bits the word
    assign rd_rec_words = mem[rd_ptr_i[`MCI_TRACE_RD_PTR_W-1:
                                       `MCI_TRACE_RD_PTR_W-`MCI_TRACE_PTR_W]];
    assign rd_word_o    = rd_rec_words[rd_ptr_i[`MCI_TRACE_RD_PTR_W-`MCI_TRACE_PTR_W-1:0]];

    always_comb begin
        status_o         = '0;
        status_o.wrapped = wrapped_q;
        status_o.valid   = valid_q;
    end

    assign wr_ptr_o = wr_ptr_q;

endmodule

// File: hdl/mci_trace_capture.sv
/* Capture stage of the trace path, one cycle from trace strobe to record.
   Repacks the trace port fields into the stored record layout. */
module mci_trace_capture
    import mci_trace_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            trace_valid_i,
    input  mci_trace_port_t trace_i,
    output logic            rec_wr_o,
    output mci_trace_rec_t  rec_o
);

    mci_trace_rec_t rec_d;
    mci_trace_rec_t rec_q;
    logic           rec_wr_q;

    // Field repacking
    always_comb begin
        rec_d                = '0;
        rec_d.insn           = trace_i.insn;
        rec_d.addr           = trace_i.addr;
        rec_d.tval           = trace_i.tval;
        rec_d.info.ecause    = trace_i.ecause;
        rec_d.info.exception = trace_i.exception;
        rec_d.info.interrupt = trace_i.interrupt;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rec_wr_q <= 1'b0;
        end else begin
            rec_wr_q <= trace_valid_i;
        end
    end

    // Record only follows a valid beat
    always_ff @(posedge clk) begin
        if (trace_valid_i) begin
            rec_q <= rec_d;
        end
    end

    assign rec_wr_o = rec_wr_q;
    assign rec_o    = rec_q;

endmodule

// File: hdl/mci_dmi_pkg.sv
/* Types of the debug module register port and the trace status word.
   Imported by the DMI register block, the ring and the top level. */
`include "mci_trace_macros.svh"

package mci_dmi_pkg;

    typedef logic [`MCI_DMI_DATA_W-1:0] mci_dmi_word_t;

    // One DMI access, en is a single cycle strobe
    typedef struct packed {
        logic                       en;
        logic                       wr_en;
        logic [`MCI_DMI_ADDR_W-1:0] addr;
        mci_dmi_word_t              wdata;
    } mci_dmi_req_t;

    // Trace buffer status
    typedef struct packed {
        logic [29:0] rsvd;
        logic        valid;
        logic        wrapped;
    } mci_trace_status_t;

endpackage

// File: hdl/mci_trace_pkg.sv
/* Types for the processor trace port and the record kept in the buffer.
   Imported by the capture stage, the ring and the top level. */
`include "mci_trace_macros.svh"

package mci_trace_pkg;

    // Retired instruction trace fields, 103 bits
    typedef struct packed {
        logic [`MCI_TRACE_DATA_W-1:0]  insn;
        logic [`MCI_TRACE_DATA_W-1:0]  addr;
        logic                          exception;
        logic [`MCI_TRACE_CAUSE_W-1:0] ecause;
        logic                          interrupt;
        logic [`MCI_TRACE_DATA_W-1:0]  tval;
    } mci_trace_port_t;

    // Word 3 of a record
    typedef struct packed {
        logic [21:0]                   rsvd_hi;
        logic                          interrupt;
        logic                          exception;
        logic [2:0]                    rsvd_lo;
        logic [`MCI_TRACE_CAUSE_W-1:0] ecause;
    } mci_trace_info_t;

    // Word 0 sits in the low bits, so the record maps onto a word array
    typedef struct packed {
        mci_trace_info_t               info;
        logic [`MCI_TRACE_DATA_W-1:0]  tval;
        logic [`MCI_TRACE_DATA_W-1:0]  addr;
        logic [`MCI_TRACE_DATA_W-1:0]  insn;
    } mci_trace_rec_t;

endpackage

// File: include/mci_trace_macros.svh
/* Sizes, field widths and DMI register map of the MCU trace buffer.
   Include this header wherever these constants are needed. */
`ifndef MCI_TRACE_MACROS_SVH
`define MCI_TRACE_MACROS_SVH

// Record storage
`define MCI_TRACE_DEPTH      8
`define MCI_TRACE_PTR_W      3
`define MCI_TRACE_WORDS      4
// Record index in upper bits, word index in lower bits
`define MCI_TRACE_RD_PTR_W   5

// Trace port field widths
`define MCI_TRACE_DATA_W     32
`define MCI_TRACE_CAUSE_W    5

// DMI side
`define MCI_DMI_ADDR_W       7
`define MCI_DMI_DATA_W       32

// DMI register map
`define MCI_DMI_STATUS_ADDR  7'h50
`define MCI_DMI_WR_PTR_ADDR  7'h51
`define MCI_DMI_RD_PTR_ADDR  7'h52
`define MCI_DMI_DATA_ADDR    7'h53

`endif
